// File: verilog.f
source/flight_pkg.sv
source/rate_cmd_if.sv
source/angle_controller.sv
source/rate_controller.sv
source/motor_mixer.sv
source/flight_core.sv
tests/tb_flight_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_flight_core
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_flight_core.sv
`timescale 1ns/1ps

module tb_flight_core
	import flight_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS = 5;
	// watchdog budget, 40 cycles per test
	localparam int TIMEOUT_NS = NUM_TESTS * 40 * CLK_PERIOD;

	logic us_clk;
	logic resetn;
	logic start;
	rx_t throttle_target, yaw_target, pitch_target, roll_target;
	fix_t pitch_actual, roll_actual;
	fix_t yaw_gyro, pitch_gyro, roll_gyro;
	logic motor_credit;
	logic busy;
	logic motor_valid;
	motor_t m0, m1, m2, m3;

	integer seed;
	// expected motor words {m0, m1, m2, m3}, pushed at each start
	logic [63:0] exp_q[$];
	// results checked so far, owned by the output monitor
	int rd_idx;
	// set to starve the mixer of returned credits
	logic hold_credits;

	flight_core flight_core_inst (
		.us_clk(us_clk), .resetn(resetn), .start(start),
		.throttle_target(throttle_target), .yaw_target(yaw_target),
		.pitch_target(pitch_target), .roll_target(roll_target),
		.pitch_actual(pitch_actual), .roll_actual(roll_actual),
		.yaw_gyro(yaw_gyro), .pitch_gyro(pitch_gyro), .roll_gyro(roll_gyro),
		.motor_credit(motor_credit), .busy(busy), .motor_valid(motor_valid),
		.m0(m0), .m1(m1), .m2(m2), .m3(m3)
	);

	initial begin
		us_clk = 1'b0;
		forever #(CLK_PERIOD / 2) us_clk = ~us_clk;
	end

	task automatic fail(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_motor(input string name, input motor_t expected, input motor_t actual);
		if (actual !== expected) begin
			fail($sformatf("error at %0t: %s expected %0d got %0d", $time, name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail($sformatf("error at %0t: %s expected %0b got %0b", $time, name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			fail($sformatf("error at %0t: %s expected %0d got %0d", $time, name, expected, actual));
		end
	endtask

	function automatic int bound(int value, int lo, int hi);
		if (value > hi) begin
			return hi;
		end
		return (value < lo) ? lo : value;
	endfunction

	// proportional loop, correction and output both limited
	function automatic int rate_loop(int command, int gyro);
		int corr;
		corr = bound(RATE_KP * (command - gyro), -CORR_MAX, CORR_MAX);
		return bound(command + corr, -CORR_MAX, CORR_MAX);
	endfunction

	function automatic motor_t motor_level(int sum);
		return motor_t'(bound(sum, 0, int'(MOTOR_MAX)));
	endfunction

	// reference model of one control cycle, result goes to the queue
	task automatic predict(input rx_t tt, yt, pt, rt, input fix_t pa, ra, yg, pg, rg);
		int thr;
		int yr;
		int pr;
		int rr;
		int lim;
		lim = int'(ANGLE_RATE_MAX);
		thr = int'(tt) * 4;
		if (thr > int'(THROTTLE_MAX)) begin
			thr = int'(THROTTLE_MAX);
		end
		// pitch imu inverted, roll imu direct
		yr = bound(int'(yt) * 4 - int'(MAP_OFFSET), -lim, lim);
		pr = bound(int'(pt) * 4 - int'(MAP_OFFSET) - int'(pa), -lim, lim);
		rr = bound(int'(rt) * 4 - int'(MAP_OFFSET) + int'(ra), -lim, lim);
		yr = rate_loop(yr, int'(yg));
		pr = rate_loop(pr, int'(pg));
		rr = rate_loop(rr, int'(rg));
		exp_q.push_back({motor_level(thr + pr + rr - yr), motor_level(thr + pr - rr + yr),
			motor_level(thr - pr - rr - yr), motor_level(thr - pr + rr + yr)});
	endtask

	// one start pulse once the angle stage is idle; inputs stay held afterwards
	task automatic launch(input rx_t tt, yt, pt, rt, input fix_t pa, ra, yg, pg, rg);
		@(negedge us_clk);
		while (busy) @(negedge us_clk);
		throttle_target = tt;
		yaw_target = yt;
		pitch_target = pt;
		roll_target = rt;
		pitch_actual = pa;
		roll_actual = ra;
		yaw_gyro = yg;
		pitch_gyro = pg;
		roll_gyro = rg;
		predict(tt, yt, pt, rt, pa, ra, yg, pg, rg);
		start = 1'b1;
		@(negedge us_clk);
		start = 1'b0;
	endtask

	task automatic wait_drained();
		while (rd_idx != exp_q.size()) @(negedge us_clk);
	endtask

	task automatic run_one(input rx_t tt, yt, pt, rt, input fix_t pa, ra, yg, pg, rg);
		launch(tt, yt, pt, rt, pa, ra, yg, pg, rg);
		wait_drained();
	endtask

	function automatic rx_t random_target();
		return rx_t'($unsigned($random(seed)) % 251);
	endfunction

	function automatic fix_t random_fix(int span);
		return fix_t'($random(seed) % (span + 1));
	endfunction

	task automatic idle_after_reset();
		check_flag("busy", 1'b0, busy);
		check_flag("motor_valid", 1'b0, motor_valid);
		repeat (12) begin
			@(negedge us_clk);
			check_flag("motor_valid", 1'b0, motor_valid);
		end
	endtask

	task automatic centred_hover();
		int cycles;
		launch(8'd125, 8'd125, 8'd125, 8'd125, '0, '0, '0, '0, '0);
		// launch returns one cycle after start was raised
		cycles = 1;
		while (!motor_valid) begin
			@(negedge us_clk);
			cycles++;
		end
		check_count("motor_valid latency", 6, cycles);
		check_motor("m0", motor_t'(500), m0);
		wait_drained();
	endtask

	task automatic extreme_limits();
		run_one(8'd250, 8'd0, 8'd250, 8'd0, '0, '0, '0, '0, '0);
		run_one(8'd0, 8'd250, 8'd0, 8'd250, '0, '0, -16'sd900, 16'sd900, -16'sd900);
		run_one(8'd255, 8'd0, 8'd0, 8'd250, 16'sd300, 16'sd300, 16'sd999, -16'sd999, 16'sd0);
	endtask

	task automatic imu_and_random();
		run_one(8'd125, 8'd125, 8'd125, 8'd125, 16'sd120, -16'sd80, '0, '0, '0);
		run_one(8'd200, 8'd125, 8'd140, 8'd110, -16'sd60, 16'sd45, 16'sd20, -16'sd35, 16'sd10);
		repeat (3) begin
			run_one(random_target(), random_target(), random_target(), random_target(),
				random_fix(300), random_fix(300), random_fix(900), random_fix(900),
				random_fix(900));
		end
	endtask

	task automatic credit_backpressure();
		int base;
		base = rd_idx;
		hold_credits = 1'b1;
		// two results drain, two fill the rate buffer, the last parks in COMPLETE
		repeat (5) begin
			launch(random_target(), random_target(), random_target(), random_target(),
				16'sd30, -16'sd20, 16'sd50, -16'sd60, 16'sd70);
		end
		repeat (12) @(negedge us_clk);
		check_count("results without credit", MOTOR_CREDITS, rd_idx - base);
		check_flag("busy", 1'b1, busy);
		hold_credits = 1'b0;
		wait_drained();
	endtask

	// output monitor and credit return to the mixer
	initial begin
		logic [63:0] expected;
		int owed;
		motor_credit = 1'b0;
		rd_idx = 0;
		owed = 0;
		forever begin
			@(negedge us_clk);
			if (resetn && motor_valid) begin
				if (rd_idx >= exp_q.size()) begin
					fail("motor_valid was raised with no result outstanding");
				end
				expected = exp_q[rd_idx];
				check_motor("m0", expected[63:48], m0);
				check_motor("m1", expected[47:32], m1);
				check_motor("m2", expected[31:16], m2);
				check_motor("m3", expected[15:0], m3);
				rd_idx++;
				owed++;
			end
			// one credit pulse per cycle while any are owed
			if (!hold_credits && (owed > 0)) begin
				motor_credit = 1'b1;
				owed--;
			end else begin
				motor_credit = 1'b0;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		fail("timeout, the tests did not finish in the expected time");
	end

	initial begin
		seed = 36130;
		hold_credits = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		throttle_target = '0;
		yaw_target = '0;
		pitch_target = '0;
		roll_target = '0;
		pitch_actual = '0;
		roll_actual = '0;
		yaw_gyro = '0;
		pitch_gyro = '0;
		roll_gyro = '0;
		repeat (10) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;
		idle_after_reset();
		centred_hover();
		extreme_limits();
		imu_and_random();
		credit_backpressure();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: source/flight_core.sv
`timescale 1ns/1ps

module flight_core
	import flight_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	input logic start,
	input rx_t throttle_target,
	input rx_t yaw_target,
	input rx_t pitch_target,
	input rx_t roll_target,
	input fix_t pitch_actual,
	input fix_t roll_actual,
	input fix_t yaw_gyro,
	input fix_t pitch_gyro,
	input fix_t roll_gyro,
	input logic motor_credit,
	output logic busy,
	output logic motor_valid,
	output motor_t m0,
	output motor_t m1,
	output motor_t m2,
	output motor_t m3
);

	// angle to rate link, credit based
	rate_cmd_if cmd_bus ();

	// rate to mixer link
	logic rate_valid;
	logic accept;
	fix_t throttle_rate, yaw_rate, pitch_rate, roll_rate;

	angle_controller angle_controller_inst (
		.us_clk(us_clk),
		.resetn(resetn),
		.start(start),
		.throttle_target(throttle_target),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.pitch_actual(pitch_actual),
		.roll_actual(roll_actual),
		.busy(busy),
		.cmd(cmd_bus.src)
	);

	rate_controller rate_controller_inst (
		.us_clk(us_clk),
		.resetn(resetn),
		.cmd(cmd_bus.dst),
		.yaw_gyro(yaw_gyro),
		.pitch_gyro(pitch_gyro),
		.roll_gyro(roll_gyro),
		.rate_valid(rate_valid),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate),
		.accept(accept)
	);

	// output credits come straight from the downstream consumer
	motor_mixer motor_mixer_inst (
		.us_clk(us_clk),
		.resetn(resetn),
		.rate_valid(rate_valid),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate),
		.accept(accept),
		.motor_credit(motor_credit),
		.motor_valid(motor_valid),
		.m0(m0),
		.m1(m1),
		.m2(m2),
		.m3(m3)
	);

endmodule

// File: source/motor_mixer.sv
`timescale 1ns/1ps

module motor_mixer
	import flight_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	input logic rate_valid,
	input fix_t throttle_rate,
	input fix_t yaw_rate,
	input fix_t pitch_rate,
	input fix_t roll_rate,
	output logic accept,
	input logic motor_credit,
	output logic motor_valid,
	output motor_t m0,
	output motor_t m1,
	output motor_t m2,
	output motor_t m3
);

	logic [MOTOR_CNT_W-1:0] credits;

	int t, y, p, r;

	function automatic motor_t clamp_motor(int sum);
		return motor_t'(sat(sum, 0, int'(MOTOR_MAX)));
	endfunction

	// sign-extended copies for the wide sums
	assign t = int'(throttle_rate);
	assign y = int'(yaw_rate);
	assign p = int'(pitch_rate);
	assign r = int'(roll_rate);

	// a result already in the rate output register holds one credit
	assign accept = credits > MOTOR_CNT_W'(rate_valid);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			credits <= MOTOR_CNT_W'(MOTOR_CREDITS);
			motor_valid <= 1'b0;
		end else begin
			// credit is spent as the rate result is taken in
			credits <= credits + MOTOR_CNT_W'(motor_credit) - MOTOR_CNT_W'(rate_valid);
			motor_valid <= rate_valid;
		end
	end

	// quad-x layout
	// front pair pitch +, right side roll -, diagonal pairs share yaw sign
	always_ff @(posedge us_clk) begin
		if (rate_valid) begin
			m0 <= clamp_motor(t + p + r - y);
			m1 <= clamp_motor(t + p - r + y);
			m2 <= clamp_motor(t - p - r - y);
			m3 <= clamp_motor(t - p + r + y);
		end
	end

	// consumer must not return more credits than it was granted,
	// and the rate stage only delivers against a held credit
	a_motor_credits: assert property (@(posedge us_clk) disable iff (!resetn)
		(credits <= MOTOR_CREDITS) && !(rate_valid && (credits == '0)));

endmodule

// File: source/rate_controller.sv
`timescale 1ns/1ps

module rate_controller
	import flight_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	rate_cmd_if.dst cmd,
	input fix_t yaw_gyro,
	input fix_t pitch_gyro,
	input fix_t roll_gyro,
	output logic rate_valid,
	output fix_t throttle_rate,
	output fix_t yaw_rate,
	output fix_t pitch_rate,
	output fix_t roll_rate,
	input logic accept
);

	// command buffer, one entry per credit
	fix_t throttle_mem [CMD_CREDITS];
	fix_t yaw_mem [CMD_CREDITS];
	fix_t pitch_mem [CMD_CREDITS];
	fix_t roll_mem [CMD_CREDITS];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [CMD_CNT_W-1:0] count;
	logic pop;

	fix_t head_throttle, head_yaw, head_pitch, head_roll;

	// command plus kp * (command - gyro), both steps saturated
	function automatic fix_t rate_axis(fix_t target, fix_t gyro);
		int corr;
		corr = sat(RATE_KP * (int'(target) - int'(gyro)), -CORR_MAX, CORR_MAX);
		return fix_t'(sat(int'(target) + corr, -CORR_MAX, CORR_MAX));
	endfunction

	function automatic logic [FIFO_PTR_W-1:0] ptr_next(logic [FIFO_PTR_W-1:0] ptr);
		if (ptr == FIFO_PTR_W'(CMD_CREDITS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// fall-through: an empty buffer hands the incoming command straight on
	assign head_throttle = (count == '0) ? cmd.throttle : throttle_mem[rd_ptr];
	assign head_yaw = (count == '0) ? cmd.yaw : yaw_mem[rd_ptr];
	assign head_pitch = (count == '0) ? cmd.pitch : pitch_mem[rd_ptr];
	assign head_roll = (count == '0) ? cmd.roll : roll_mem[rd_ptr];

	// mixer back-pressure stalls the pop
	assign pop = ((count != '0) || cmd.cmd_valid) && accept;
	// freed entry goes back as a credit in the same cycle
	assign cmd.cmd_credit = pop;

	always_ff @(posedge us_clk) begin
		if (cmd.cmd_valid) begin
			throttle_mem[wr_ptr] <= cmd.throttle;
			yaw_mem[wr_ptr] <= cmd.yaw;
			pitch_mem[wr_ptr] <= cmd.pitch;
			roll_mem[wr_ptr] <= cmd.roll;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rate_valid <= 1'b0;
		end else begin
			if (cmd.cmd_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			count <= count + CMD_CNT_W'(cmd.cmd_valid) - CMD_CNT_W'(pop);
			rate_valid <= pop;
		end
	end

	// p-only loop, gyro sampled at the pop
	always_ff @(posedge us_clk) begin
		if (pop) begin
			throttle_rate <= head_throttle;
			yaw_rate <= rate_axis(head_yaw, yaw_gyro);
			pitch_rate <= rate_axis(head_pitch, pitch_gyro);
			roll_rate <= rate_axis(head_roll, roll_gyro);
		end
	end

	// source must hold back while every entry is taken
	a_no_overflow: assert property (@(posedge us_clk) disable iff (!resetn)
		!(cmd.cmd_valid && (count == CMD_CNT_W'(CMD_CREDITS))));

endmodule

// File: source/angle_controller.sv
`timescale 1ns/1ps

module angle_controller
	import flight_pkg::*;
(
	input logic us_clk,
	input logic resetn,
	input logic start,
	input rx_t throttle_target,
	input rx_t yaw_target,
	input rx_t pitch_target,
	input rx_t roll_target,
	input fix_t pitch_actual,
	input fix_t roll_actual,
	output logic busy,
	rate_cmd_if.src cmd
);

	logic [4:0] state;
	logic [4:0] next_state;
	logic [CMD_CNT_W-1:0] credits;

	// targets captured when a cycle starts
	rx_t latched_throttle;
	rx_t latched_yaw;
	rx_t latched_pitch;
	rx_t latched_roll;

	fix_t mapped_throttle, mapped_yaw, mapped_pitch, mapped_roll;
	fix_t scaled_throttle, scaled_yaw, scaled_pitch, scaled_roll;

	// receiver 0..250 becomes 0..1000 raw, then centred around zero
	function automatic fix_t map_centred(rx_t target);
		return fix_t'({6'b000000, target, 2'b00}) - MAP_OFFSET;
	endfunction

	function automatic fix_t limit_rate(fix_t value);
		return fix_t'(sat(int'(value), int'(ANGLE_RATE_MIN), int'(ANGLE_RATE_MAX)));
	endfunction

	// hold in COMPLETE until the rate stage has room
	assign cmd.cmd_valid = (state == STATE_COMPLETE) && (credits != '0);
	assign busy = (state != STATE_WAITING);

	always_comb begin
		case (state)
			STATE_WAITING: next_state = start ? STATE_MAPPING : STATE_WAITING;
			STATE_MAPPING: next_state = STATE_SCALING;
			STATE_SCALING: next_state = STATE_LIMITING;
			STATE_LIMITING: next_state = STATE_COMPLETE;
			STATE_COMPLETE: next_state = (credits != '0) ? STATE_WAITING : STATE_COMPLETE;
			default: next_state = STATE_WAITING;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= STATE_WAITING;
			credits <= CMD_CNT_W'(CMD_CREDITS);
		end else begin
			state <= next_state;
			// a returned credit and a new valid in one cycle cancel out
			credits <= credits + CMD_CNT_W'(cmd.cmd_credit) - CMD_CNT_W'(cmd.cmd_valid);
		end
	end

	always_ff @(posedge us_clk) begin
		case (state)
			STATE_WAITING: begin
				if (start) begin
					latched_throttle <= throttle_target;
					latched_yaw <= yaw_target;
					latched_pitch <= pitch_target;
					latched_roll <= roll_target;
				end
			end
			STATE_MAPPING: begin
				mapped_throttle <= fix_t'({6'b000000, latched_throttle, 2'b00});
				mapped_yaw <= map_centred(latched_yaw);
				// imu pitch axis is mounted inverted, so it subtracts
				mapped_pitch <= map_centred(latched_pitch) - pitch_actual;
				mapped_roll <= map_centred(latched_roll) + roll_actual;
			end
			STATE_SCALING: begin
				scaled_throttle <= mapped_throttle * RATE_SCALE;
				scaled_yaw <= mapped_yaw * RATE_SCALE;
				scaled_pitch <= mapped_pitch * RATE_SCALE;
				scaled_roll <= mapped_roll * RATE_SCALE;
			end
			STATE_LIMITING: begin
				// throttle has an upper bound only
				if (scaled_throttle > THROTTLE_MAX) begin
					cmd.throttle <= THROTTLE_MAX;
				end else begin
					cmd.throttle <= scaled_throttle;
				end
				cmd.yaw <= limit_rate(scaled_yaw);
				cmd.pitch <= limit_rate(scaled_pitch);
				cmd.roll <= limit_rate(scaled_roll);
				// errors go out before the limit
				cmd.pitch_err <= mapped_pitch;
				cmd.roll_err <= mapped_roll;
			end
			default: begin
			end
		endcase
	end

	// credit return from the rate stage keeps the count bounded
	a_cmd_credits: assert property (@(posedge us_clk) disable iff (!resetn)
		(credits <= CMD_CREDITS) && !(cmd.cmd_valid && (credits == '0)));

endmodule

// File: source/rate_cmd_if.sv
`timescale 1ns/1ps

interface rate_cmd_if
	import flight_pkg::*;
();

	// one cycle strobe, costs the source one credit
	logic cmd_valid;
	// limited rate commands
	fix_t throttle;
	fix_t yaw;
	fix_t pitch;
	fix_t roll;
	// unclamped mapped angle errors
	fix_t pitch_err;
	fix_t roll_err;
	// one pulse per freed buffer entry
	logic cmd_credit;

	modport src (
		output cmd_valid, throttle, yaw, pitch, roll, pitch_err, roll_err,
		input cmd_credit
	);

	modport dst (
		input cmd_valid, throttle, yaw, pitch, roll, pitch_err, roll_err,
		output cmd_credit
	);

endinterface

// File: source/flight_pkg.sv
package flight_pkg;

	// signed 12.4 fixed point used for every rate, angle and error
	typedef logic signed [15:0] fix_t;
	// raw receiver target, 0 to 250 in normal use
	typedef logic [7:0] rx_t;
	// motor command handed to the pwm stage
	typedef logic [15:0] motor_t;

	// angle stage limits, raw units
	localparam fix_t THROTTLE_MAX = 16'sd4032;
	localparam fix_t ANGLE_RATE_MAX = 16'sd400;
	localparam fix_t ANGLE_RATE_MIN = -ANGLE_RATE_MAX;
	// centre of the receiver range after the x4 mapping
	localparam fix_t MAP_OFFSET = 16'sd500;
	// unity scale, the stage only keeps its slot in the pipeline
	localparam fix_t RATE_SCALE = 16'sd1;

	// proportional gain of the rate loop
	localparam int RATE_KP = 2;
	// bound on the correction and on each corrected rate
	localparam int CORR_MAX = 800;

	// top of the motor command range
	localparam motor_t MOTOR_MAX = 16'd4095;

	// depth of the rate command buffer, one credit per entry
	localparam int CMD_CREDITS = 2;
	// credits granted by the motor consumer after reset
	localparam int MOTOR_CREDITS = 2;
	localparam int CMD_CNT_W = $clog2(CMD_CREDITS + 1);
	localparam int MOTOR_CNT_W = $clog2(MOTOR_CREDITS + 1);
	localparam int FIFO_PTR_W = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;

	// one-hot angle sequencer states
	localparam logic [4:0] STATE_WAITING = 5'b00001;
	localparam logic [4:0] STATE_MAPPING = 5'b00010;
	localparam logic [4:0] STATE_SCALING = 5'b00100;
	localparam logic [4:0] STATE_LIMITING = 5'b01000;
	localparam logic [4:0] STATE_COMPLETE = 5'b10000;

	// saturate a wide intermediate into [lo, hi]
	function automatic int sat(int value, int lo, int hi);
		if (value > hi) begin
			return hi;
		end
		if (value < lo) begin
			return lo;
		end
		return value;
	endfunction

endpackage
